// ==== Bender.yml ====
package:
  name: cp0

sources:
  - include_dirs:
      - hw
    files:
      - hw/cp0Pkg.sv
      - hw/excSelect.sv
      - hw/cp0Timer.sv
      - hw/excRegs.sv
      - hw/cp0BusPort.sv
      - hw/cp0Top.sv
      - target: simulation
        files:
          - tb/cp0Tb.sv

// ==== compile.f ====
+incdir+hw
hw/cp0Pkg.sv
hw/excSelect.sv
hw/cp0Timer.sv
hw/excRegs.sv
hw/cp0BusPort.sv
hw/cp0Top.sv
tb/cp0Tb.sv

// ==== hw/cp0BusPort.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0BusPort (
    input  logic            clk,
    input  logic            rst,
    input  cp0Pkg::wbReqT   wbReq_i,
    input  cp0Pkg::cp0ViewT view_i,
    output cp0Pkg::wbRspT   wbRsp_o,
    output cp0Pkg::cp0WrT   wr_o
);

    logic         req;
    logic         ack;
    cp0Pkg::wordT readMux;
    cp0Pkg::wordT rdata;

    // new request only while no ack is outstanding
    assign req = wbReq_i.cyc && wbReq_i.stb && !ack;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    always_comb begin
        case (wbReq_i.adr)
            cp0Pkg::STATUS:   readMux = view_i.status;
            cp0Pkg::CAUSE:    readMux = view_i.cause;
            cp0Pkg::EPC:      readMux = view_i.epc;
            cp0Pkg::BADVADDR: readMux = view_i.badVAddr;
            cp0Pkg::COUNT:    readMux = view_i.count;
            cp0Pkg::COMPARE:  readMux = view_i.compare;
            default:          readMux = '0;
        endcase
    end

    // strobes land on the same edge that raises ack
    always_comb begin
        wr_o = '0;
        wr_o.wdata = wbReq_i.dat;
        if (req && wbReq_i.we) begin
            case (wbReq_i.adr)
                cp0Pkg::STATUS:  wr_o.status = 1'b1;
                cp0Pkg::CAUSE:   wr_o.cause = 1'b1;
                cp0Pkg::EPC:     wr_o.epc = 1'b1;
                cp0Pkg::COUNT:   wr_o.count = 1'b1;
                cp0Pkg::COMPARE: wr_o.compare = 1'b1;
                // badvaddr is read only
                default:         ;
            endcase
        end
    end

    // --------------------------------------------------
    // response
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdata <= readMux;
        end
    end

    assign wbRsp_o.ack = ack;
    assign wbRsp_o.dat = rdata;

    ackAfterStb: assert property (@(posedge clk) disable iff (!rst)
        ack |-> ($past(wbReq_i.cyc && wbReq_i.stb) && !$past(ack)))
        else $error("cp0BusPort: ack without a preceding strobe");

endmodule

`default_nettype wire

// ==== hw/cp0Pkg.sv ====
`default_nettype none
`include "cp0_consts.svh"

package cp0Pkg;

    typedef logic [`CP0_DATA_W-1:0] wordT;

    // cause codes as encoded in Cause.ExcCode
    typedef enum logic [`CP0_EXCCODE_W-1:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } excCodeE;

    // {rd, sel}
    typedef enum logic [7:0] {
        BADVADDR = 8'h40,
        COUNT    = 8'h48,
        COMPARE  = 8'h58,
        STATUS   = 8'h60,
        CAUSE    = 8'h68,
        EPC      = 8'h70
    } cp0RegE;

    typedef enum logic [1:0] {NONE, EXE, PREMEM, MEM} excSegE;

    typedef struct packed {
        logic    hasExc;
        excCodeE excCode;
        logic    isDelaySlot;
        wordT    pc;
        wordT    badVAddr;
        logic    eret;
    } excInfoT;

    // risk set means the instruction in that stage may still be squashed
    typedef struct packed {
        excInfoT exe;
        excInfoT preMem;
        excInfoT mem;
        logic    exeRisk;
        logic    preMemRisk;
        logic    memRisk;
    } stageExcT;

    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        cp0RegE adr;
        wordT   dat;
    } wbReqT;

    typedef struct packed {
        logic ack;
        wordT dat;
    } wbRspT;

    // one-hot software write strobes
    typedef struct packed {
        logic status;
        logic cause;
        logic epc;
        logic count;
        logic compare;
        wordT wdata;
    } cp0WrT;

    typedef struct packed {
        wordT status;
        wordT cause;
        wordT epc;
        wordT badVAddr;
        wordT count;
        wordT compare;
    } cp0ViewT;

    typedef struct packed {
        logic occur;
        wordT destPc;
    } redirectT;

endpackage

`default_nettype wire

// ==== hw/cp0Timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0Timer (
    input  logic          clk,
    input  logic          rst,
    input  cp0Pkg::cp0WrT wr_i,
    output cp0Pkg::wordT  count_o,
    output cp0Pkg::wordT  compare_o,
    output logic          ti_o
);

    logic         tick;
    cp0Pkg::wordT count;
    cp0Pkg::wordT compare;
    logic         ti;

    // tick rises one cycle after reset release, count follows a cycle later
    always_ff @(posedge clk) begin
        if (!rst) begin
            tick <= 1'b0;
        end else begin
            tick <= 1'b1;
        end
    end

    // --------------------------------------------------
    // count and compare
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (wr_i.count) begin
            count <= wr_i.wdata;
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            compare <= '0;
        end else if (wr_i.compare) begin
            compare <= wr_i.wdata;
        end
    end

    // timer interrupt, sticky until compare is rewritten
    always_ff @(posedge clk) begin
        if (!rst) begin
            ti <= 1'b0;
        end else if (wr_i.compare) begin
            ti <= 1'b0;
        end else if (count == compare) begin
            ti <= 1'b1;
        end
    end

    assign count_o   = count;
    assign compare_o = compare;
    assign ti_o      = ti;

    tiClearOnCompare: assert property (@(posedge clk) disable iff (!rst)
        wr_i.compare |=> !ti_o)
        else $error("cp0Timer: TI still set after compare write");

endmodule

`default_nettype wire

// ==== hw/cp0Top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0Top (
    input  logic             clk,
    input  logic             rst,
    input  cp0Pkg::wbReqT    wbReq_i,
    input  cp0Pkg::stageExcT stages_i,
    input  logic             wbRisk_i,
    input  logic [5:0]       extInt_i,
    output cp0Pkg::wbRspT    wbRsp_o,
    output cp0Pkg::redirectT redirect_o,
    output cp0Pkg::excSegE   exceptSeg_o,
    output cp0Pkg::wordT     status_o,
    output cp0Pkg::wordT     cause_o
);

    wire cp0Pkg::excInfoT selExc;
    wire cp0Pkg::cp0WrT   wr;
    wire cp0Pkg::cp0ViewT view;
    wire                  ti;

    excSelect u_excSelect (
        .stages_i (stages_i),
        .wbRisk_i (wbRisk_i),
        .sel_o    (selExc),
        .seg_o    (exceptSeg_o)
    );

    cp0Timer u_cp0Timer (
        .clk       (clk),
        .rst       (rst),
        .wr_i      (wr),
        .count_o   (view.count),
        .compare_o (view.compare),
        .ti_o      (ti)
    );

    excRegs u_excRegs (
        .clk        (clk),
        .rst        (rst),
        .exc_i      (selExc),
        .wr_i       (wr),
        .ti_i       (ti),
        .extInt_i   (extInt_i),
        .status_o   (view.status),
        .cause_o    (view.cause),
        .epc_o      (view.epc),
        .badVAddr_o (view.badVAddr),
        .redirect_o (redirect_o)
    );

    // software access
    cp0BusPort u_cp0BusPort (
        .clk     (clk),
        .rst     (rst),
        .wbReq_i (wbReq_i),
        .view_i  (view),
        .wbRsp_o (wbRsp_o),
        .wr_o    (wr)
    );

    assign status_o = view.status;
    assign cause_o  = view.cause;

endmodule

`default_nettype wire

// ==== hw/cp0_consts.svh ====
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// --------------------------------------------------
// datapath widths
// --------------------------------------------------
`define CP0_DATA_W 32
`define CP0_EXCCODE_W 5

// --------------------------------------------------
// redirect targets
// --------------------------------------------------
// general exception entry with BEV set
`define CP0_EXC_VECTOR 32'hbfc00380

// epc points back at the branch for a delay-slot fault
`define CP0_EPC_DS_ADJ 32'd4

// --------------------------------------------------
// register field positions
// --------------------------------------------------
// status
`define CP0_STATUS_IE 0
`define CP0_STATUS_EXL 1
`define CP0_STATUS_IM_LO 8
`define CP0_STATUS_IM_HI 15

// cause
`define CP0_CAUSE_EXC_LO 2
`define CP0_CAUSE_IP_LO 8
`define CP0_CAUSE_TI 30
`define CP0_CAUSE_BD 31

`endif

// ==== hw/excRegs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cp0_consts.svh"

module excRegs (
    input  logic             clk,
    input  logic             rst,
    input  cp0Pkg::excInfoT  exc_i,
    input  cp0Pkg::cp0WrT    wr_i,
    input  logic             ti_i,
    input  logic [5:0]       extInt_i,
    output cp0Pkg::wordT     status_o,
    output cp0Pkg::wordT     cause_o,
    output cp0Pkg::wordT     epc_o,
    output cp0Pkg::wordT     badVAddr_o,
    output cp0Pkg::redirectT redirect_o
);

    logic            exl;
    logic            ie;
    logic [7:0]      im;
    logic            bd;
    logic [7:0]      ip;
    cp0Pkg::excCodeE excCode;
    cp0Pkg::wordT    epc;
    cp0Pkg::wordT    badVAddr;
    logic            commit;
    logic            addrFault;

    // a fault inside the handler is ignored
    assign commit = exc_i.hasExc && !exl;

    // codes that carry a faulting virtual address
    assign addrFault = exc_i.excCode inside {cp0Pkg::ADEL, cp0Pkg::ADES,
                                             cp0Pkg::TLBL, cp0Pkg::TLBS, cp0Pkg::MOD};

    // --------------------------------------------------
    // status
    // --------------------------------------------------
    // software write has priority over commit and eret
    always_ff @(posedge clk) begin
        if (!rst) begin
            exl <= 1'b0;
        end else if (wr_i.status) begin
            exl <= wr_i.wdata[`CP0_STATUS_EXL];
        end else if (commit) begin
            exl <= 1'b1;
        end else if (exc_i.eret) begin
            exl <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ie <= 1'b0;
            im <= '0;
        end else if (wr_i.status) begin
            ie <= wr_i.wdata[`CP0_STATUS_IE];
            im <= wr_i.wdata[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO];
        end
    end

    // --------------------------------------------------
    // cause
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            bd      <= 1'b0;
            excCode <= cp0Pkg::INT;
        end else if (commit) begin
            bd      <= exc_i.isDelaySlot;
            excCode <= exc_i.excCode;
        end
    end

    // hardware lines with the timer folded into ip7
    always_ff @(posedge clk) begin
        if (!rst) begin
            ip[7:2] <= '0;
        end else begin
            ip[7:2] <= {extInt_i[5] | ti_i, extInt_i[4:0]};
        end
    end

    // software interrupt bits are the only writable part of cause
    always_ff @(posedge clk) begin
        if (!rst) begin
            ip[1:0] <= '0;
        end else if (wr_i.cause) begin
            ip[1:0] <= wr_i.wdata[`CP0_CAUSE_IP_LO+1:`CP0_CAUSE_IP_LO];
        end
    end

    // --------------------------------------------------
    // epc and badvaddr
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (commit) begin
            if (exc_i.isDelaySlot) begin
                epc <= exc_i.pc - `CP0_EPC_DS_ADJ;
            end else begin
                epc <= exc_i.pc;
            end
        end else if (wr_i.epc) begin
            epc <= wr_i.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (commit && addrFault) begin
            badVAddr <= exc_i.badVAddr;
        end
    end

    // register images
    always_comb begin
        status_o = '0;
        status_o[`CP0_STATUS_IE] = ie;
        status_o[`CP0_STATUS_EXL] = exl;
        status_o[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO] = im;

        cause_o = '0;
        cause_o[`CP0_CAUSE_BD] = bd;
        cause_o[`CP0_CAUSE_TI] = ti_i;
        cause_o[`CP0_CAUSE_IP_LO +: 8] = ip;
        cause_o[`CP0_CAUSE_EXC_LO +: `CP0_EXCCODE_W] = excCode;
    end

    assign epc_o      = epc;
    assign badVAddr_o = badVAddr;

    // pipeline flush in the same cycle as the selected record
    always_comb begin
        redirect_o.occur  = commit || exc_i.eret;
        redirect_o.destPc = '0;
        if (commit) begin
            redirect_o.destPc = `CP0_EXC_VECTOR;
        end else if (exc_i.eret) begin
            redirect_o.destPc = epc;
        end
    end

    occurHasCause: assert property (@(posedge clk) disable iff (!rst)
        redirect_o.occur |-> (commit || exc_i.eret))
        else $error("excRegs: redirect without commit or eret");

endmodule

`default_nettype wire

// ==== hw/excSelect.sv ====
`timescale 1ns/100ps
`default_nettype none

module excSelect (
    input  cp0Pkg::stageExcT stages_i,
    input  logic             wbRisk_i,
    output cp0Pkg::excInfoT  sel_o,
    output cp0Pkg::excSegE   seg_o
);

    // --------------------------------------------------
    // risk based priority
    // --------------------------------------------------
    // a stage may only raise its record once everything behind it
    // is known to retire, so the youngest safe stage wins
    always_comb begin
        if (!stages_i.preMemRisk) begin
            sel_o = stages_i.exe;
            seg_o = cp0Pkg::EXE;
        end else if (!stages_i.memRisk) begin
            sel_o = stages_i.preMem;
            seg_o = cp0Pkg::PREMEM;
        end else if (!wbRisk_i) begin
            sel_o = stages_i.mem;
            seg_o = cp0Pkg::MEM;
        end else begin
            // every stage still speculative
            sel_o = '0;
            seg_o = cp0Pkg::NONE;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // nothing may commit while no stage is selected
    noneHasNoExc: assert final (seg_o != cp0Pkg::NONE || !sel_o.hasExc)
        else $error("excSelect: exception record with segment NONE");

    // an eret and a fault never come from one record
    noEretWithExc: assert final (!(sel_o.hasExc && sel_o.eret))
        else $error("excSelect: selected record carries both eret and exception");

endmodule

`default_nettype wire

// ==== tb/cp0Tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "cp0_consts.svh"

module cp0Tb;

    localparam int CYCLE_LIMIT = 2000;
    localparam logic [31:0] STATUS_MASK = 32'h0000_ff03;
    localparam logic [31:0] CAUSE_EXC_MASK = 32'h8000_007c;

    logic              clk;
    logic              rst;
    cp0Pkg::wbReqT     wbReq;
    cp0Pkg::wbRspT     wbRsp;
    cp0Pkg::stageExcT  stages;
    logic              wbRisk;
    logic [5:0]        extInt;
    cp0Pkg::redirectT  redirect;
    cp0Pkg::excSegE    exceptSeg;
    cp0Pkg::wordT      statusOut;
    cp0Pkg::wordT      causeOut;

    // bookkeeping
    string             testName;
    int                errorCount;
    int                startErrors;
    int                testCount;
    int                cycleCount;
    logic [31:0]       lfsrState;
    logic [31:0]       epcModel;
    logic              expectEret;
    cp0Pkg::excSegE    lastSeg;
    cp0Pkg::redirectT  lastRedirect;

    cp0Top u_dut (
        .clk         (clk),
        .rst         (rst),
        .wbReq_i     (wbReq),
        .stages_i    (stages),
        .wbRisk_i    (wbRisk),
        .extInt_i    (extInt),
        .wbRsp_o     (wbRsp),
        .redirect_o  (redirect),
        .exceptSeg_o (exceptSeg),
        .status_o    (statusOut),
        .cause_o     (causeOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // concurrent checks
    // --------------------------------------------------
    ackLatency: assert property (@(posedge clk) disable iff (!rst)
        (wbReq.cyc && wbReq.stb && !wbRsp.ack) |=> wbRsp.ack)
        else begin
            $display("%s: ack did not follow strobe after one cycle", testName);
            errorCount++;
        end

    ackSingle: assert property (@(posedge clk) disable iff (!rst)
        wbRsp.ack |=> !wbRsp.ack)
        else begin
            $display("%s: ack stayed high for more than one cycle", testName);
            errorCount++;
        end

    redirectVector: assert property (@(posedge clk) disable iff (!rst)
        (redirect.occur && !expectEret) |-> redirect.destPc == `CP0_EXC_VECTOR)
        else begin
            $display("%s: exception redirect went to the wrong target", testName);
            errorCount++;
        end

    redirectEpc: assert property (@(posedge clk) disable iff (!rst)
        (redirect.occur && expectEret) |-> redirect.destPc == epcModel)
        else begin
            $display("%s: eret redirect did not go to EPC", testName);
            errorCount++;
        end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic cp0Pkg::stageExcT idleStages();
        cp0Pkg::stageExcT s;
        s = '0;
        s.preMemRisk = 1'b1;
        s.memRisk = 1'b1;
        return s;
    endfunction

    function automatic cp0Pkg::excInfoT makeRecord(input cp0Pkg::excCodeE code,
            input logic ds, input logic [31:0] pc, input logic [31:0] bad);
        cp0Pkg::excInfoT rec;
        rec = '0;
        rec.hasExc = 1'b1;
        rec.excCode = code;
        rec.isDelaySlot = ds;
        rec.pc = pc;
        rec.badVAddr = bad;
        return rec;
    endfunction

    task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        startErrors = errorCount;
    endtask

    task automatic finishTest();
        testCount++;
        $display("test %s finished with %0d errors", testName, errorCount - startErrors);
    endtask

    // ack sampled on the falling edge
    task automatic waitAck();
        do begin
            @(negedge clk);
        end while (!wbRsp.ack);
    endtask

    task automatic wbWrite(input cp0Pkg::cp0RegE adr, input logic [31:0] dat);
        @(posedge clk);
        wbReq.cyc <= 1'b1;
        wbReq.stb <= 1'b1;
        wbReq.we  <= 1'b1;
        wbReq.adr <= adr;
        wbReq.dat <= dat;
        waitAck();
        @(posedge clk);
        wbReq.cyc <= 1'b0;
        wbReq.stb <= 1'b0;
        wbReq.we  <= 1'b0;
    endtask

    task automatic wbRead(input cp0Pkg::cp0RegE adr, output logic [31:0] data);
        @(posedge clk);
        wbReq.cyc <= 1'b1;
        wbReq.stb <= 1'b1;
        wbReq.we  <= 1'b0;
        wbReq.adr <= adr;
        waitAck();
        data = wbRsp.dat;
        @(posedge clk);
        wbReq.cyc <= 1'b0;
        wbReq.stb <= 1'b0;
    endtask

    // one-cycle exception or eret pulse with the redirect sampled mid-cycle
    task automatic offerException(input cp0Pkg::stageExcT s, input logic wbR,
            input logic isEret);
        @(posedge clk);
        stages <= s;
        wbRisk <= wbR;
        expectEret <= isEret;
        @(negedge clk);
        lastSeg = exceptSeg;
        lastRedirect = redirect;
        @(posedge clk);
        stages <= idleStages();
        wbRisk <= 1'b1;
        expectEret <= 1'b0;
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    initial begin
        cp0Pkg::stageExcT s;
        logic [31:0]      v;
        logic [31:0]      r;
        logic [31:0]      pc;
        logic [31:0]      bad;
        logic [31:0]      causeSaved;
        logic             ds;
        logic             seen;

        rst = 1'b0;
        wbReq = '0;
        wbReq.adr = cp0Pkg::STATUS;
        stages = idleStages();
        wbRisk = 1'b1;
        extInt = '0;
        expectEret = 1'b0;
        errorCount = 0;
        testCount = 0;
        cycleCount = 0;
        lfsrState = 32'h236a5279;
        epcModel = '0;
        testName = "reset";
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);

        startTest("busAccess");
        v = randomBits(32) & 32'hffff_fffc;
        wbWrite(cp0Pkg::EPC, v);
        epcModel = v;
        wbRead(cp0Pkg::EPC, r);
        checkValue(v, r);
        v = randomBits(32);
        wbWrite(cp0Pkg::COMPARE, v);
        wbRead(cp0Pkg::COMPARE, r);
        checkValue(v, r);
        v = randomBits(32);
        wbWrite(cp0Pkg::STATUS, v);
        wbRead(cp0Pkg::STATUS, r);
        checkValue(v & STATUS_MASK, r);
        @(negedge clk);
        checkValue(v & STATUS_MASK, statusOut);
        wbRead(cp0Pkg::cp0RegE'(8'h10), r);
        checkValue(32'd0, r);
        wbWrite(cp0Pkg::STATUS, 32'd0);
        finishTest();

        startTest("excPriority");
        pc = randomBits(32) & 32'hffff_fffc;
        ds = randomBits(1) != 0;
        s = idleStages();
        s.exe = makeRecord(cp0Pkg::OV, 1'b0, pc ^ 32'h100, 32'd0);
        s.preMem = makeRecord(cp0Pkg::RI, ds, pc, 32'd0);
        s.memRisk = 1'b0;
        offerException(s, 1'b1, 1'b0);
        checkValue(32'(cp0Pkg::PREMEM), 32'(lastSeg));
        checkValue(32'd1, 32'(lastRedirect.occur));
        epcModel = ds ? pc - `CP0_EPC_DS_ADJ : pc;
        wbRead(cp0Pkg::STATUS, r);
        checkValue(32'h2, r & 32'h2);
        wbRead(cp0Pkg::CAUSE, r);
        causeSaved = r & CAUSE_EXC_MASK;
        checkValue({ds, 24'd0, 5'(cp0Pkg::RI), 2'd0}, causeSaved);
        wbRead(cp0Pkg::EPC, r);
        checkValue(epcModel, r);
        finishTest();

        startTest("nestedExc");
        s = idleStages();
        s.exe = makeRecord(cp0Pkg::SYS, !ds, randomBits(32) & 32'hffff_fffc, 32'd0);
        s.preMemRisk = 1'b0;
        offerException(s, 1'b1, 1'b0);
        checkValue(32'd0, 32'(lastRedirect.occur));
        wbRead(cp0Pkg::EPC, r);
        checkValue(epcModel, r);
        wbRead(cp0Pkg::CAUSE, r);
        checkValue(causeSaved, r & CAUSE_EXC_MASK);
        finishTest();

        startTest("eret");
        s = idleStages();
        s.exe.eret = 1'b1;
        s.preMemRisk = 1'b0;
        offerException(s, 1'b1, 1'b1);
        checkValue(32'd1, 32'(lastRedirect.occur));
        checkValue(epcModel, lastRedirect.destPc);
        wbRead(cp0Pkg::STATUS, r);
        checkValue(32'd0, r & 32'h2);
        finishTest();

        startTest("badVAddr");
        bad = randomBits(32);
        pc = randomBits(32) & 32'hffff_fffc;
        s = idleStages();
        s.mem = makeRecord(cp0Pkg::ADEL, 1'b0, pc, bad);
        offerException(s, 1'b0, 1'b0);
        epcModel = pc;
        checkValue(32'(cp0Pkg::MEM), 32'(lastSeg));
        wbRead(cp0Pkg::BADVADDR, r);
        checkValue(bad, r);
        wbWrite(cp0Pkg::STATUS, 32'd0);
        s.mem = makeRecord(cp0Pkg::SYS, 1'b0, pc + 32'd8, ~bad);
        offerException(s, 1'b0, 1'b0);
        epcModel = pc + 32'd8;
        wbRead(cp0Pkg::BADVADDR, r);
        checkValue(bad, r);
        wbWrite(cp0Pkg::STATUS, 32'd0);
        finishTest();

        startTest("timerInt");
        v = randomBits(32) & 32'h7fff_ffff;
        wbWrite(cp0Pkg::COUNT, v);
        wbWrite(cp0Pkg::COMPARE, v + 32'd20);
        seen = 1'b0;
        for (int i = 0; i < 40 && !seen; i++) begin
            @(negedge clk);
            seen = causeOut[`CP0_CAUSE_TI] && causeOut[`CP0_CAUSE_IP_LO+7];
        end
        assert (seen) else begin
            $display("%s: Cause.TI and Cause.IP7 were not both set within 40 cycles",
                     testName);
            errorCount++;
        end
        wbWrite(cp0Pkg::COMPARE, v + 32'd100000);
        @(negedge clk);
        checkValue(32'd0, 32'(causeOut[`CP0_CAUSE_TI]));
        @(posedge clk);
        extInt <= 6'b000100;
        repeat (2) @(negedge clk);
        checkValue(32'd1, 32'(causeOut[`CP0_CAUSE_IP_LO+4]));
        @(posedge clk);
        extInt <= '0;
        finishTest();

        repeat (2) @(posedge clk);
        $display("tests run %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
